// File: bench/hasti_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module hasti_mem_tb;
  import hasti_pkg::*;

  localparam int clk_half_p = 50;
  // outputs are read a quarter period after the falling edge.
  localparam int sample_delay_p = 25;

  typedef enum logic [1:0] {rec_test, rec_xfer, rec_sync, rec_lcg} rec_kind_e;

  typedef struct packed {
    rec_kind_e kind;
    logic      port;
    logic      chain;
    logic      wr;
    haddr_t    addr;
    hsize_t    size;
    hdata_t    wdata;
    hdata_t    exp_data;
  } rec_t;

  logic    clk_i;
  logic    reset_i;
  haddr_t  haddr [2];
  logic    hwrite [2];
  hsize_t  hsize [2];
  htrans_t htrans [2];
  hdata_t  hwdata [2];
  hdata_t  hrdata [2];
  logic    hready [2];
  logic    hresp [2];

  rec_t        recs [$];
  string       test_names [$];
  rec_t        port0_q [$];
  rec_t        port1_q [$];
  int          check_count = 0;
  int          err_count = 0;
  int          test_count = 0;
  int          test_checks_start = 0;
  int          test_errs_start = 0;
  int          cycle_count = 0;
  int          cycle_limit = 100;
  int          xfer_lines = 0;
  string       cur_test;
  logic [31:0] lcg_state = 32'd73;
  // word model of the bank for the generated traffic.
  hdata_t      model [mem_words_p];
  bit          used [mem_words_p];

  hasti_mem_top dut
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .h0_haddr_i  (haddr[0]),
    .h0_hwrite_i (hwrite[0]),
    .h0_hsize_i  (hsize[0]),
    .h0_htrans_i (htrans[0]),
    .h0_hwdata_i (hwdata[0]),
    .h0_hrdata_o (hrdata[0]),
    .h0_hready_o (hready[0]),
    .h0_hresp_o  (hresp[0]),
    .h1_haddr_i  (haddr[1]),
    .h1_hwrite_i (hwrite[1]),
    .h1_hsize_i  (hsize[1]),
    .h1_htrans_i (htrans[1]),
    .h1_hwdata_i (hwdata[1]),
    .h1_hrdata_o (hrdata[1]),
    .h1_hready_o (hready[1]),
    .h1_hresp_o  (hresp[1])
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_half_p) clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("simulation timed out after %0d cycles", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("ERR at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic rec_t get_xfer(input int p, input int i);
    if (p == 0)
    begin
      return port0_q[i];
    end
    else
    begin
      return port1_q[i];
    end
  endfunction

  task automatic push_xfer(input rec_t x);
    if (x.port)
    begin
      port1_q.push_back(x);
    end
    else
    begin
      port0_q.push_back(x);
    end
  endtask

  // one AHB master. an upper case op presents its address phase
  // while the previous transfer is still in its data phase.
  task automatic run_port(input int p);
    int   n;
    int   a;
    int   d;
    int   waited;
    int   wait_limit;
    logic show_addr;
    logic done;
    rec_t cur;
    rec_t nxt;
    n = (p == 0) ? port0_q.size() : port1_q.size();
    a = 0;
    d = -1;
    waited = 0;
    cur = '0;
    nxt = '0;
    while (a < n || d >= 0)
    begin
      @(negedge clk_i);
      if (a < n)
      begin
        nxt = get_xfer(p, a);
      end
      show_addr = (a < n) && (d < 0 || nxt.chain);
      if (show_addr)
      begin
        haddr[p] = nxt.addr;
        hwrite[p] = nxt.wr;
        hsize[p] = nxt.size;
        htrans[p] = htrans_nonseq_p;
      end
      else
      begin
        htrans[p] = htrans_idle_p;
      end
      if (d >= 0 && cur.wr)
      begin
        hwdata[p] = cur.wdata;
      end
      #(sample_delay_p);
      check_value(32'(hresp[p]), 32'd0, $sformatf("port %0d hresp", p));
      done = (d >= 0) && hready[p];
      if (d >= 0)
      begin
        waited++;
      end
      if (done)
      begin
        if (!cur.wr)
        begin
          check_value(hrdata[p], cur.exp_data, $sformatf("port %0d read %h", p, cur.addr));
        end
        // a loser waits one grant, a chained read also waits for its own write.
        wait_limit = cur.chain ? 3 : 2;
        check_value(32'(waited <= wait_limit), 32'd1,
                    $sformatf("port %0d wait bound at %h", p, cur.addr));
        d = -1;
      end
      if (show_addr && d < 0)
      begin
        cur = nxt;
        d = a;
        a++;
        waited = 0;
      end
    end
  endtask

  task automatic run_queues();
    fork
      run_port(0);
      run_port(1);
    join
    port0_q.delete();
    port1_q.delete();
  endtask

  task automatic run_lcg(input int count);
    mem_index_t  idx_list [$];
    logic [31:0] r;
    mem_index_t  idx;
    rec_t        x;
    for (int i = 0; i < count; i++)
    begin
      do
      begin
        r = lcg_next();
        idx = r[15:8];
      end
      while (used[idx]);
      used[idx] = 1'b1;
      x = '0;
      x.kind = rec_xfer;
      x.port = i[0];
      x.wr = 1'b1;
      x.addr = haddr_t'({idx, 2'b00});
      x.size = hsize_word_p;
      x.wdata = lcg_next();
      model[idx] = x.wdata;
      idx_list.push_back(idx);
      push_xfer(x);
    end
    run_queues();
    // each word is read back through the other port.
    for (int i = 0; i < count; i++)
    begin
      x = '0;
      x.kind = rec_xfer;
      x.port = ~i[0];
      x.addr = haddr_t'({idx_list[i], 2'b00});
      x.size = hsize_word_p;
      x.exp_data = model[idx_list[i]];
      push_xfer(x);
    end
    run_queues();
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_checks_start = check_count;
    test_errs_start = err_count;
  endtask

  task automatic finish_test();
    $display("test %-14s %0d checks, %0d errors", cur_test,
             check_count - test_checks_start, err_count - test_errs_start);
    test_count++;
  endtask

  task automatic load_tests();
    int     fd;
    int     n;
    int     port_v;
    int     size_v;
    int     count_v;
    string  line;
    string  word;
    string  name;
    string  op;
    haddr_t addr_v;
    hdata_t wdata_v;
    hdata_t exp_v;
    rec_t   r;
    fd = $fopen("bench/hasti_mem_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the tests file bench/hasti_mem_tests.txt");
      $display("SIMULATION FAILED");
      $finish;
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        word = "";
        n = $sscanf(line, "%s", word);
        if (n >= 1 && word.getc(0) != "#")
        begin
          r = '0;
          if (word == "test")
          begin
            n = $sscanf(line, "%s %s", word, name);
            r.kind = rec_test;
            test_names.push_back(name);
          end
          else if (word == "sync")
          begin
            r.kind = rec_sync;
          end
          else if (word == "lcg")
          begin
            n = $sscanf(line, "%s %d", word, count_v);
            r.kind = rec_lcg;
            r.addr = haddr_t'(count_v);
            xfer_lines += 2 * count_v;
          end
          else
          begin
            n = $sscanf(line, "%d %s %h %d %h %h", port_v, op, addr_v, size_v, wdata_v, exp_v);
            check_value(32'(n), 32'd6, "fields on a tests file line");
            r.kind = rec_xfer;
            r.port = (port_v != 0);
            r.wr = (op == "w" || op == "W");
            r.chain = (op == "R" || op == "W");
            r.addr = addr_v;
            r.size = hsize_t'(size_v);
            r.wdata = wdata_v;
            r.exp_data = exp_v;
            xfer_lines++;
          end
          recs.push_back(r);
        end
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    int ti;
    bit test_open;
    ti = 0;
    test_open = 1'b0;
    reset_i = 1'b1;
    for (int p = 0; p < 2; p++)
    begin
      haddr[p] = '0;
      hwrite[p] = 1'b0;
      hsize[p] = hsize_word_p;
      htrans[p] = htrans_idle_p;
      hwdata[p] = '0;
    end
    load_tests();
    cycle_limit = 20 * xfer_lines + 100;
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;

    // with nothing presented neither port may signal ready.
    start_test("reset_idle");
    repeat (3)
    begin
      @(negedge clk_i);
      #(sample_delay_p);
      check_value(32'(hready[0]), 32'd0, "port 0 hready while idle");
      check_value(32'(hready[1]), 32'd0, "port 1 hready while idle");
    end
    finish_test();

    foreach (recs[i])
    begin
      case (recs[i].kind)
        rec_test:
        begin
          run_queues();
          if (test_open)
          begin
            finish_test();
          end
          start_test(test_names[ti]);
          ti++;
          test_open = 1'b1;
        end
        rec_xfer:
        begin
          push_xfer(recs[i]);
        end
        rec_sync:
        begin
          run_queues();
        end
        default:
        begin
          run_queues();
          run_lcg(int'(recs[i].addr));
        end
      endcase
    end
    run_queues();
    if (test_open)
    begin
      finish_test();
    end

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/hasti_mem_tests.txt
# port op addr size wdata expected; op r/w waits for the previous transfer, R/W chains onto it.
# size 0 byte, 1 halfword, 2 word; "sync" waits for both ports, "lcg n" runs n generated writes.
test word_rw
1 w 00000100 2 a5a55a5a 00000000
1 r 00000100 2 00000000 a5a55a5a
test byte_half
1 w 00000200 2 11223344 00000000
1 w 00000201 0 ffffaaff 00000000
1 w 00000203 0 bbccddee 00000000
1 r 00000200 2 00000000 bb22aa44
1 w 00000200 0 99999977 00000000
1 w 00000202 0 12665432 00000000
1 r 00000200 2 00000000 bb66aa77
1 w 00000204 2 00000000 00000000
1 w 00000204 1 ffff1234 00000000
1 w 00000206 1 5678ffff 00000000
1 r 00000204 2 00000000 56781234
1 w 00000208 2 cafef00d 00000000
1 w 0000020a 1 beef0000 00000000
1 r 00000208 2 00000000 beeff00d
test shared
1 w 00000300 2 0badf00d 00000000
sync
0 r 00000300 2 00000000 0badf00d
test contention
0 w 00000040 2 01010101 00000000
1 w 00000080 2 02020202 00000000
0 w 00000044 2 03030303 00000000
1 w 00000084 2 04040404 00000000
sync
0 r 00000080 2 00000000 02020202
1 r 00000040 2 00000000 01010101
0 r 00000084 2 00000000 04040404
1 r 00000044 2 00000000 03030303
sync
0 r 00000044 2 00000000 03030303
1 w 00000088 2 05050505 00000000
0 w 0000004c 2 06060606 00000000
1 r 00000080 2 00000000 02020202
test back_to_back
1 w 000003f0 2 13579bdf 00000000
1 r 000003f0 2 00000000 13579bdf
1 W 000003f0 2 2468ace0 00000000
1 r 000003f0 2 00000000 2468ace0
0 w 000003f4 2 76543210 00000000
0 R 000003f4 2 00000000 76543210
test lcg
lcg 16

// File: common/hasti_pkg.sv
`default_nettype none

package hasti_pkg;

  // bus widths of the AHB-lite ports.
  localparam int haddr_width_p = 32;
  localparam int hdata_width_p = 32;
  localparam int hdata_nbytes_p = 4;
  localparam int hsize_width_p = 3;
  localparam int htrans_width_p = 2;

  // the bank holds 256 words, indexed by address bits 9 to 2.
  localparam int mem_words_p = 256;
  localparam int mem_index_width_p = 8;

  typedef logic [haddr_width_p-1:0] haddr_t;
  typedef logic [hdata_width_p-1:0] hdata_t;
  typedef logic [hsize_width_p-1:0] hsize_t;
  typedef logic [htrans_width_p-1:0] htrans_t;
  // a set bit keeps that byte unchanged.
  typedef logic [hdata_nbytes_p-1:0] byte_mask_t;
  typedef logic [mem_index_width_p-1:0] mem_index_t;

  // htrans encodings.
  localparam htrans_t htrans_idle_p = 2'd0;
  localparam htrans_t htrans_nonseq_p = 2'd2;

  // hsize encodings.
  localparam hsize_t hsize_byte_p = 3'd0;
  localparam hsize_t hsize_half_p = 3'd1;
  localparam hsize_t hsize_word_p = 3'd2;

  // round-robin priority of the memory arbiter.
  typedef enum logic
  {
    prio_port0,
    prio_port1
  } grant_state_e;

endpackage

`default_nettype wire

// File: common/mem_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if;
  import hasti_pkg::*;

  // request side, held stable while v is high and yumi is low.
  logic       v;
  logic       w;
  haddr_t     addr;
  hdata_t     data;
  byte_mask_t mask;
  logic       yumi;

  // read return, one cycle after an accepted read.
  logic       rvalid;
  hdata_t     rdata;

  modport requester
  (
    output v, w, addr, data, mask,
    input  yumi, rvalid, rdata
  );

  modport server
  (
    input  v, w, addr, data, mask,
    output yumi, rvalid, rdata
  );

endinterface

`default_nettype wire

// File: converter/hasti_converter.sv
`timescale 1ns/10ps
`default_nettype none

module hasti_converter
  (
    input  logic               clk_i,
    input  logic               reset_i,
    input  hasti_pkg::haddr_t  haddr_i,
    input  logic               hwrite_i,
    input  hasti_pkg::hsize_t  hsize_i,
    input  hasti_pkg::htrans_t htrans_i,
    input  hasti_pkg::hdata_t  hwdata_i,
    output hasti_pkg::hdata_t  hrdata_o,
    output logic               hready_o,
    output logic               hresp_o,
    mem_req_if.requester       mem
  );
  import hasti_pkg::*;

  // a held transfer is either a write waiting in its data phase
  // or a read that was not accepted in its address phase.
  logic       trans_r;
  logic       w_r;
  haddr_t     addr_r;
  hsize_t     size_r;

  logic       nonseq;
  logic       free;
  logic       live_rd;
  haddr_t     addr_sel;
  hsize_t     size_sel;
  byte_mask_t size_pattern;

  assign nonseq = (htrans_i == htrans_nonseq_p);

  // a write ends when the arbiter takes it, a read when its data returns.
  assign hready_o = mem.rvalid | (trans_r & w_r & mem.yumi);

  // a new address phase is taken when nothing is held or the held one ends now.
  assign free = ~trans_r | hready_o;

  // reads go out in their address phase on the live address.
  assign live_rd = ~trans_r & nonseq & ~hwrite_i;

  assign addr_sel = trans_r ? addr_r : haddr_i;
  assign size_sel = trans_r ? size_r : hsize_i;

  always_comb
  begin
    case (size_sel)
      hsize_byte_p: size_pattern = byte_mask_t'(4'h1);
      hsize_half_p: size_pattern = byte_mask_t'(4'h3);
      hsize_word_p: size_pattern = byte_mask_t'(4'hF);
      default:      size_pattern = byte_mask_t'(4'hF);
    endcase
  end

  assign mem.v    = trans_r | live_rd;
  assign mem.w    = trans_r & w_r;
  assign mem.addr = addr_sel;
  assign mem.data = hwdata_i;
  // the memory side expects a 0 on every byte that is written.
  assign mem.mask = ~byte_mask_t'(size_pattern << addr_sel[1:0]);

  assign hrdata_o = mem.rdata;
  assign hresp_o  = 1'b0;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      trans_r <= 1'b0;
      w_r     <= 1'b0;
    end
    else if (free)
    begin
      // a live read taken at once needs nothing held.
      trans_r <= nonseq & (hwrite_i | ~(live_rd & mem.yumi));
      w_r     <= hwrite_i;
    end
    else if (mem.yumi)
    begin
      trans_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (free)
    begin
      addr_r <= haddr_i;
      size_r <= hsize_i;
    end
  end

  // an unaccepted request must stay put, including a live read
  // that moves into the held registers.
  property p_req_held;
    @(posedge clk_i) disable iff (reset_i)
      mem.v && !mem.yumi |=>
        mem.v && $stable(mem.addr) && $stable(mem.w) && $stable(mem.mask);
  endproperty

  a_req_held: assert property (p_req_held)
    else $error("request changed before it was accepted");

  // the cycle after a reset edge has no transfer state and no read return.
  a_no_ready_after_reset: assert property (@(posedge clk_i) $past(reset_i) |-> !hready_o)
    else $error("hready asserted under reset");

endmodule

`default_nettype wire

// File: files.f
common/hasti_pkg.sv
common/mem_req_if.sv
converter/hasti_converter.sv
memory/mem_arbiter.sv
memory/mem_bank.sv
logic/hasti_mem_top.sv
bench/hasti_mem_tb.sv

// File: logic/hasti_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module hasti_mem_top
  (
    input  logic               clk_i,
    input  logic               reset_i,
    // instruction port.
    input  hasti_pkg::haddr_t  h0_haddr_i,
    input  logic               h0_hwrite_i,
    input  hasti_pkg::hsize_t  h0_hsize_i,
    input  hasti_pkg::htrans_t h0_htrans_i,
    input  hasti_pkg::hdata_t  h0_hwdata_i,
    output hasti_pkg::hdata_t  h0_hrdata_o,
    output logic               h0_hready_o,
    output logic               h0_hresp_o,
    // data port.
    input  hasti_pkg::haddr_t  h1_haddr_i,
    input  logic               h1_hwrite_i,
    input  hasti_pkg::hsize_t  h1_hsize_i,
    input  hasti_pkg::htrans_t h1_htrans_i,
    input  hasti_pkg::hdata_t  h1_hwdata_i,
    output hasti_pkg::hdata_t  h1_hrdata_o,
    output logic               h1_hready_o,
    output logic               h1_hresp_o
  );
  import hasti_pkg::*;

  logic       bank_en;
  logic       bank_we;
  mem_index_t bank_index;
  hdata_t     bank_wdata;
  byte_mask_t bank_mask;
  hdata_t     bank_rdata;

  mem_req_if req0 ();
  mem_req_if req1 ();

  hasti_converter u_conv0
  (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .haddr_i  (h0_haddr_i),
    .hwrite_i (h0_hwrite_i),
    .hsize_i  (h0_hsize_i),
    .htrans_i (h0_htrans_i),
    .hwdata_i (h0_hwdata_i),
    .hrdata_o (h0_hrdata_o),
    .hready_o (h0_hready_o),
    .hresp_o  (h0_hresp_o),
    .mem      (req0)
  );

  hasti_converter u_conv1
  (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .haddr_i  (h1_haddr_i),
    .hwrite_i (h1_hwrite_i),
    .hsize_i  (h1_hsize_i),
    .htrans_i (h1_htrans_i),
    .hwdata_i (h1_hwdata_i),
    .hrdata_o (h1_hrdata_o),
    .hready_o (h1_hready_o),
    .hresp_o  (h1_hresp_o),
    .mem      (req1)
  );

  mem_arbiter u_arb
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .port0        (req0),
    .port1        (req1),
    .bank_rdata_i (bank_rdata),
    .bank_en_o    (bank_en),
    .bank_we_o    (bank_we),
    .bank_index_o (bank_index),
    .bank_wdata_o (bank_wdata),
    .bank_mask_o  (bank_mask)
  );

  mem_bank u_bank
  (
    .clk_i   (clk_i),
    .en_i    (bank_en),
    .we_i    (bank_we),
    .index_i (bank_index),
    .wdata_i (bank_wdata),
    .mask_i  (bank_mask),
    .rdata_o (bank_rdata)
  );

endmodule

`default_nettype wire

// File: memory/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
  (
    input  logic                  clk_i,
    input  logic                  reset_i,
    mem_req_if.server             port0,
    mem_req_if.server             port1,
    input  hasti_pkg::hdata_t     bank_rdata_i,
    output logic                  bank_en_o,
    output logic                  bank_we_o,
    output hasti_pkg::mem_index_t bank_index_o,
    output hasti_pkg::hdata_t     bank_wdata_o,
    output hasti_pkg::byte_mask_t bank_mask_o
  );
  import hasti_pkg::*;

  grant_state_e prio_r;
  logic         grant0;
  logic         grant1;
  logic         rd_v_r;
  logic         rd_port_r;
  haddr_t       sel_addr;

  // a lone requester always wins, otherwise the priority decides.
  assign grant0 = port0.v & (~port1.v | (prio_r == prio_port0));
  assign grant1 = port1.v & (~port0.v | (prio_r == prio_port1));

  assign port0.yumi = grant0;
  assign port1.yumi = grant1;

  assign sel_addr = grant1 ? port1.addr : port0.addr;

  assign bank_en_o    = grant0 | grant1;
  assign bank_we_o    = grant1 ? port1.w : port0.w;
  assign bank_index_o = sel_addr[mem_index_width_p+1:2];
  assign bank_wdata_o = grant1 ? port1.data : port0.data;
  assign bank_mask_o  = grant1 ? port1.mask : port0.mask;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      prio_r    <= prio_port0;
      rd_v_r    <= 1'b0;
      rd_port_r <= 1'b0;
    end
    else
    begin
      // priority only turns over when both ports asked.
      if (port0.v && port1.v)
      begin
        prio_r <= grant0 ? prio_port1 : prio_port0;
      end
      rd_v_r    <= bank_en_o & ~bank_we_o;
      rd_port_r <= grant1;
    end
  end

  // bank data is registered, so it lines up with the delayed read flag.
  assign port0.rvalid = rd_v_r & ~rd_port_r;
  assign port1.rvalid = rd_v_r & rd_port_r;
  assign port0.rdata  = bank_rdata_i;
  assign port1.rdata  = bank_rdata_i;

  a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i)
    !(port0.yumi && port1.yumi))
    else $error("both ports granted in one cycle");

  a_rvalid0: assert property (@(posedge clk_i) disable iff (reset_i)
    port0.v && port0.yumi && !port0.w |=> port0.rvalid)
    else $error("port 0 read accepted without a return");

  a_rvalid1: assert property (@(posedge clk_i) disable iff (reset_i)
    port1.v && port1.yumi && !port1.w |=> port1.rvalid)
    else $error("port 1 read accepted without a return");

endmodule

`default_nettype wire

// File: memory/mem_bank.sv
`timescale 1ns/10ps
`default_nettype none

module mem_bank
  (
    input  logic                  clk_i,
    input  logic                  en_i,
    input  logic                  we_i,
    input  hasti_pkg::mem_index_t index_i,
    input  hasti_pkg::hdata_t     wdata_i,
    input  hasti_pkg::byte_mask_t mask_i,
    output hasti_pkg::hdata_t     rdata_o
  );
  import hasti_pkg::*;

  hdata_t mem_r [mem_words_p];
  hdata_t rdata_r;

  // bytes with a set mask bit keep their old value.
  always_ff @(posedge clk_i)
  begin
    if (en_i && we_i)
    begin
      for (int b = 0; b < hdata_nbytes_p; b++)
      begin
        if (!mask_i[b])
        begin
          mem_r[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read data shows up the cycle after the access.
  always_ff @(posedge clk_i)
  begin
    if (en_i && !we_i)
    begin
      rdata_r <= mem_r[index_i];
    end
  end

  assign rdata_o = rdata_r;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f files.f \
  --top-module hasti_mem_tb \
  -o hasti_mem_sim &&
  ./obj_dir/hasti_mem_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
  echo "run_sim: testbench passed" ||
  {
    echo "run_sim: build or simulation failed" >&2
    exit 1
  }
